//--- Makefile
# Verilator build and run of the vector unit testbench

VERILATOR ?= verilator
TOP ?= tb_vec_unit
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0
PASS_MSG ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- actf/vpu_actf_unit.sv
// Fixed walk of one thread per cycle; i_leaky and i_shift must stay stable until o_done
`include "vpu_params.svh"

module vpu_actf_unit import vpu_pkg::*; (
	input  logic				clk,
	input  logic				i_rst_n,
	// Dispatcher side
	input  logic				i_disp,
	input  logic				i_leaky,
	input  shamt_t				i_shift,
	output logic				o_done,
	// Register values
	input  acc_t				i_acc [0:`VPU_THREADS-1],
	input  logic [`VPU_THREADS-1:0]	i_en,
	// Register file write port
	output logic				o_wr_en,
	output th_t				o_th,
	output acc_t				o_data
);

	localparam int NTH = `VPU_THREADS;	// Thread count

	walk_state_t	state_q;
	th_t		th_q;		// Thread under evaluation
	logic		last_th;	// Final thread of the walk
	acc_t		cur_acc;	// Accumulator of current thread
	logic		cur_neg;	// Current accumulator below zero

	// ======================================================================
	// Thread walker
	// ======================================================================

	assign last_th = (th_q == th_t'(NTH - 1));

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= WS_IDLE;
			th_q <= '0;
		end else begin
			case (state_q)
			WS_IDLE: begin
				if (i_disp) begin
					state_q <= WS_WALK;
					th_q <= '0;		// Always start at thread 0
				end
			end
			WS_WALK: begin
				th_q <= th_q + 1'b1;		// One thread per cycle
				if (last_th) begin
					state_q <= WS_IDLE;
				end
			end
			default: state_q <= WS_IDLE;
			endcase
		end
	end

	// ======================================================================
	// ReLU / leaky ReLU datapath
	// ======================================================================

	assign cur_acc = i_acc[th_q];
	assign cur_neg = cur_acc[31];			// Sign bit

	// Only negative values on enabled threads change
	assign o_wr_en = (state_q == WS_WALK) && i_en[th_q] && cur_neg;
	assign o_th = th_q;
	assign o_data = i_leaky ? (cur_acc >>> i_shift) : acc_t'(0);	// Arithmetic shift keeps sign
	assign o_done = (state_q == WS_WALK) && last_th;

endmodule

//--- common/vpu_params.svh
// Thread count and queue depth are powers of two and at least 2; payload must be 32 bits or wider
`ifndef VPU_PARAMS_SVH
`define VPU_PARAMS_SVH

// ======================================================================
// Thread configuration
// ======================================================================

`define VPU_THREADS_POW2	2				// log2 of thread count
`define VPU_THREADS		(1 << `VPU_THREADS_POW2)	// Number of hardware threads

// ======================================================================
// Command path
// ======================================================================

`define VPU_CMDQ_DEPTH_POW2	2				// log2 of command FIFO depth
`define VPU_CMDQ_DEPTH		(1 << `VPU_CMDQ_DEPTH_POW2)	// Command FIFO entries

`define VPU_PL_W		32				// Command payload width

// Payload layout used by ACTF
`define VPU_PL_LEAKY_BIT	0				// Leaky mode select
`define VPU_PL_SHIFT_LSB	1				// Shift amount low bit
`define VPU_PL_SHIFT_MSB	5				// Shift amount high bit

`endif

//--- common/vpu_pkg.sv
// Types shared by the vector unit; opcode values outside the enum are legal on the port and dropped
`include "vpu_params.svh"

package vpu_pkg;

	// ======================================================================
	// Scalar types
	// ======================================================================

	typedef logic [`VPU_THREADS_POW2-1:0]	th_t;		// Thread index
	typedef logic signed [31:0]		acc_t;		// Signed accumulator
	typedef logic [`VPU_PL_W-1:0]		pl_t;		// Command payload
	typedef logic [4:0]			shamt_t;	// Leaky ReLU shift amount

	// Command opcodes
	typedef enum logic [4:0] {
		OP_NOP		= 5'd0,		// Does nothing
		OP_SETACC	= 5'd1,		// acc[th] = pl
		OP_SETEN	= 5'd2,		// en[th] = pl[0]
		OP_ACTF		= 5'd3,		// Activation over enabled threads
		OP_STORE	= 5'd4		// Emit enabled accumulators
	} op_t;

	// ======================================================================
	// Bundles
	// ======================================================================

	typedef struct packed {
		op_t	op;	// Opcode
		th_t	th;	// Target thread for SETACC/SETEN
		pl_t	pl;	// Payload
	} cmd_t;

	typedef struct packed {
		th_t	th;	// Source thread
		acc_t	data;	// Accumulator value
	} wrq_t;

	// Dispatcher FSM
	typedef enum logic [1:0] {
		DS_IDLE,		// Ready to pop
		DS_WAIT_ACTF,		// Activation unit running
		DS_WAIT_STOR		// Store unit running
	} disp_state_t;

	// Thread walker shared by the functional units
	typedef enum logic {
		WS_IDLE,		// Waiting for dispatch
		WS_WALK			// Stepping through threads
	} walk_state_t;

endpackage

//--- logic/vpu_cmd_dispatch.sv
// One command in flight at a time; SETACC/SETEN write on the pop edge, NOP and unknown ops drop
`include "vpu_params.svh"

module vpu_cmd_dispatch import vpu_pkg::*; (
	input  logic	clk,
	input  logic	i_rst_n,
	// Command queue side
	input  logic	i_vld,
	output logic	o_rd,
	input  cmd_t	i_cmd,
	// Status
	output logic	o_busy,
	// Register update port
	output logic	o_ru_wr_en,
	output logic	o_ru_sel_en,
	output th_t	o_ru_th,
	output acc_t	o_ru_data,
	// Activation unit
	output logic	o_actf_disp,
	output logic	o_leaky,
	output shamt_t	o_shift,
	input  logic	i_actf_done,
	// Store unit
	output logic	o_stor_disp,
	input  logic	i_stor_done
);

	disp_state_t	state_q;
	disp_state_t	state_nx;
	logic		pop_ok;		// FSM can take a command this cycle
	logic		is_setacc;
	logic		is_seten;
	logic		is_actf;
	logic		is_stor;
	logic		actf_disp_q;
	logic		stor_disp_q;
	logic		leaky_q;
	shamt_t		shift_q;

	// ======================================================================
	// Decode and pop
	// ======================================================================

	assign is_setacc = (i_cmd.op == OP_SETACC);
	assign is_seten = (i_cmd.op == OP_SETEN);
	assign is_actf = (i_cmd.op == OP_ACTF);
	assign is_stor = (i_cmd.op == OP_STORE);

	always_comb begin
		case (state_q)
		DS_IDLE:	pop_ok = 1'b1;
		DS_WAIT_ACTF:	pop_ok = i_actf_done;	// Back-to-back on done
		DS_WAIT_STOR:	pop_ok = i_stor_done;
		default:	pop_ok = 1'b1;
		endcase
	end

	assign o_rd = i_vld && pop_ok;

	always_comb begin
		state_nx = state_q;
		if (pop_ok) begin
			state_nx = DS_IDLE;		// Unit finished or already idle
		end
		if (o_rd && is_actf) begin
			state_nx = DS_WAIT_ACTF;
		end else if (o_rd && is_stor) begin
			state_nx = DS_WAIT_STOR;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= DS_IDLE;
			actf_disp_q <= 1'b0;
			stor_disp_q <= 1'b0;
		end else begin
			state_q <= state_nx;
			actf_disp_q <= o_rd && is_actf;	// Disp one cycle after pop
			stor_disp_q <= o_rd && is_stor;
		end
	end

	// ACTF parameters held for the whole walk
	always_ff @(posedge clk) begin
		if (o_rd && is_actf) begin
			leaky_q <= i_cmd.pl[`VPU_PL_LEAKY_BIT];
			shift_q <= i_cmd.pl[`VPU_PL_SHIFT_MSB:`VPU_PL_SHIFT_LSB];
		end
	end

	// ======================================================================
	// Register update writes
	// ======================================================================

	assign o_ru_wr_en = o_rd && (is_setacc || is_seten);
	assign o_ru_sel_en = is_seten;			// Enable bit or accumulator
	assign o_ru_th = i_cmd.th;
	assign o_ru_data = is_seten ? acc_t'({31'b0, i_cmd.pl[0]}) : acc_t'(i_cmd.pl[31:0]);

	assign o_actf_disp = actf_disp_q;
	assign o_stor_disp = stor_disp_q;
	assign o_leaky = leaky_q;
	assign o_shift = shift_q;
	assign o_busy = (state_q != DS_IDLE);

endmodule

//--- logic/vpu_cmd_queue.sv
// Driver must hold i_cmd stable while i_cmd_sel is high and raise sel only after ack is low
`include "vpu_params.svh"

module vpu_cmd_queue import vpu_pkg::*; (
	input  logic	clk,
	input  logic	i_rst_n,
	// Four-phase command port
	input  logic	i_cmd_sel,
	input  cmd_t	i_cmd,
	output logic	o_cmd_ack,
	// To dispatcher
	output logic	o_vld,
	input  logic	i_rd,
	output cmd_t	o_cmd,
	// Status
	output logic	o_busy
);

	localparam int DEPTH = `VPU_CMDQ_DEPTH;		// FIFO entries
	localparam int AW = `VPU_CMDQ_DEPTH_POW2;	// FIFO address width

	cmd_t		fifo_mem [0:DEPTH-1];	// Command storage
	logic [AW:0]	wr_ptr;			// Write pointer with wrap flag in MSB
	logic [AW:0]	rd_ptr;			// Read pointer with wrap flag in MSB
	logic		ack_q;			// Ack phase register
	logic		fifo_empty;
	logic		fifo_full;
	logic		push;			// Accept a new command
	logic		pop;			// Dispatcher takes head

	// ======================================================================
	// FIFO status
	// ======================================================================

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);	// Same slot, different lap

	// Sel high with ack still low is a fresh command
	assign push = i_cmd_sel && !ack_q && !fifo_full;
	assign pop = o_vld && i_rd;

	// ======================================================================
	// Handshake phases
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			ack_q <= 1'b0;
		end else if (push) begin
			ack_q <= 1'b1;		// Ack the cycle after capture
		end else if (!i_cmd_sel) begin
			ack_q <= 1'b0;		// Release once sel has dropped
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr[AW-1:0]] <= i_cmd;	// Capture payload
		end
	end

	assign o_cmd_ack = ack_q;
	assign o_vld = !fifo_empty;
	assign o_cmd = fifo_mem[rd_ptr[AW-1:0]];	// Fall-through head
	assign o_busy = !fifo_empty || ack_q;		// Pending work or open handshake

endmodule

//--- logic/vpu_rf.sv
// Both write ports may hit one accumulator in the same cycle; the register update port then wins
`include "vpu_params.svh"

module vpu_rf import vpu_pkg::*; (
	input  logic				clk,
	input  logic				i_rst_n,
	// Register update port
	input  logic				i_ru_wr_en,
	input  logic				i_ru_sel_en,
	input  th_t				i_ru_th,
	input  acc_t				i_ru_data,
	// Activation unit port
	input  logic				i_actf_wr_en,
	input  th_t				i_actf_th,
	input  acc_t				i_actf_data,
	// Register values
	output acc_t				o_acc [0:`VPU_THREADS-1],
	output logic [`VPU_THREADS-1:0]	o_en
);

	localparam int NTH = `VPU_THREADS;	// Thread count

	acc_t			acc_q [0:NTH-1];	// Per-thread accumulators
	logic [NTH-1:0]		en_q;			// Per-thread enable bits
	logic [NTH-1:0]		ru_acc_hit;		// SETACC target decode
	logic [NTH-1:0]		ru_en_hit;		// SETEN target decode
	logic [NTH-1:0]		actf_hit;		// Activation target decode

	// ======================================================================
	// Write decode
	// ======================================================================

	always_comb begin
		for (int t = 0; t < NTH; t++) begin
			ru_acc_hit[t] = i_ru_wr_en && !i_ru_sel_en && (i_ru_th == th_t'(t));
			ru_en_hit[t] = i_ru_wr_en && i_ru_sel_en && (i_ru_th == th_t'(t));
			actf_hit[t] = i_actf_wr_en && (i_actf_th == th_t'(t));
		end
	end

	// ======================================================================
	// Register array
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int t = 0; t < NTH; t++) begin
				acc_q[t] <= '0;
			end
			en_q <= '0;
		end else begin
			for (int t = 0; t < NTH; t++) begin
				// Later command overrides the last activation write
				if (ru_acc_hit[t]) begin
					acc_q[t] <= i_ru_data;
				end else if (actf_hit[t]) begin
					acc_q[t] <= i_actf_data;
				end
				if (ru_en_hit[t]) begin
					en_q[t] <= i_ru_data[0];	// Enable in bit 0
				end
			end
		end
	end

	assign o_acc = acc_q;
	assign o_en = en_q;

endmodule

//--- logic/vpu_stor_unit.sv
// Register values must stay stable during the walk; disabled threads cost one idle cycle each
`include "vpu_params.svh"

module vpu_stor_unit import vpu_pkg::*; (
	input  logic				clk,
	input  logic				i_rst_n,
	// Dispatcher side
	input  logic				i_disp,
	output logic				o_done,
	// Register values
	input  acc_t				i_acc [0:`VPU_THREADS-1],
	input  logic [`VPU_THREADS-1:0]	i_en,
	// Result channel
	output logic				o_wrq_vld,
	output wrq_t				o_wrq,
	input  logic				i_wrq_rdy
);

	localparam int NTH = `VPU_THREADS;	// Thread count

	walk_state_t	state_q;
	th_t		th_q;		// Thread being emitted
	logic		last_th;	// Final thread of the walk
	logic		cur_en;		// Current thread enabled
	logic		step;		// Move to next thread

	// ======================================================================
	// Thread walker
	// ======================================================================

	assign last_th = (th_q == th_t'(NTH - 1));
	assign cur_en = i_en[th_q];
	assign step = (state_q == WS_WALK) && (!cur_en || i_wrq_rdy);	// Skip or transfer

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= WS_IDLE;
			th_q <= '0;
		end else begin
			case (state_q)
			WS_IDLE: begin
				if (i_disp) begin
					state_q <= WS_WALK;
					th_q <= '0;
				end
			end
			WS_WALK: begin
				if (step) begin
					th_q <= th_q + 1'b1;
					if (last_th) begin
						state_q <= WS_IDLE;
					end
				end
			end
			default: state_q <= WS_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Result channel
	// ======================================================================

	// Held while ready is low since th_q only moves on step
	assign o_wrq_vld = (state_q == WS_WALK) && cur_en;
	assign o_wrq.th = th_q;
	assign o_wrq.data = i_acc[th_q];
	assign o_done = step && last_th;		// Last transfer or last skip

endmodule

//--- logic/vpu_vec_unit.sv
// Four threads by default; no memory path, so a stalled result channel backs up into cmd ack
`include "vpu_params.svh"

module vpu_vec_unit import vpu_pkg::*; (
	input  logic	clk,
	input  logic	i_rst_n,
	// Command port
	input  logic	i_cmd_sel,
	input  cmd_t	i_cmd,
	output logic	o_cmd_ack,
	// Result channel
	output logic	o_wrq_vld,
	output wrq_t	o_wrq,
	input  logic	i_wrq_rdy,
	// Status
	output logic	o_busy
);

	// ======================================================================
	// Internal wiring
	// ======================================================================

	logic				cmdq_busy;
	logic				cmdq_vld;
	logic				cmdq_rd;
	cmd_t				cmdq_cmd;	// Head of queue

	logic				cmdd_busy;
	logic				cmdd_actf_disp;
	logic				cmdd_actf_done;
	logic				cmdd_stor_disp;
	logic				cmdd_stor_done;
	logic				cmdd_leaky;
	shamt_t				cmdd_shift;

	logic				ru_wr_en;	// Register update port
	logic				ru_sel_en;
	th_t				ru_th;
	acc_t				ru_data;

	logic				actf_wr_en;	// Activation write port
	th_t				actf_th;
	acc_t				actf_data;

	acc_t				rf_acc [0:`VPU_THREADS-1];
	logic [`VPU_THREADS-1:0]	rf_en;

	assign o_busy = cmdq_busy || cmdd_busy;

	// ======================================================================
	// Block instances
	// ======================================================================

	vpu_cmd_queue cmd_queue (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_cmd_sel(i_cmd_sel), .i_cmd(i_cmd), .o_cmd_ack(o_cmd_ack),
		.o_vld(cmdq_vld), .i_rd(cmdq_rd), .o_cmd(cmdq_cmd),
		.o_busy(cmdq_busy)
	);

	vpu_cmd_dispatch cmd_disp (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_vld(cmdq_vld), .o_rd(cmdq_rd), .i_cmd(cmdq_cmd),
		.o_busy(cmdd_busy),
		.o_ru_wr_en(ru_wr_en), .o_ru_sel_en(ru_sel_en),
		.o_ru_th(ru_th), .o_ru_data(ru_data),
		.o_actf_disp(cmdd_actf_disp), .o_leaky(cmdd_leaky), .o_shift(cmdd_shift),
		.i_actf_done(cmdd_actf_done),
		.o_stor_disp(cmdd_stor_disp), .i_stor_done(cmdd_stor_done)
	);

	vpu_rf rf (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_ru_wr_en(ru_wr_en), .i_ru_sel_en(ru_sel_en),
		.i_ru_th(ru_th), .i_ru_data(ru_data),
		.i_actf_wr_en(actf_wr_en), .i_actf_th(actf_th), .i_actf_data(actf_data),
		.o_acc(rf_acc), .o_en(rf_en)
	);

	vpu_actf_unit actf_unit (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_disp(cmdd_actf_disp), .i_leaky(cmdd_leaky), .i_shift(cmdd_shift),
		.o_done(cmdd_actf_done),
		.i_acc(rf_acc), .i_en(rf_en),
		.o_wr_en(actf_wr_en), .o_th(actf_th), .o_data(actf_data)
	);

	vpu_stor_unit stor_unit (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_disp(cmdd_stor_disp), .o_done(cmdd_stor_done),
		.i_acc(rf_acc), .i_en(rf_en),
		.o_wrq_vld(o_wrq_vld), .o_wrq(o_wrq), .i_wrq_rdy(i_wrq_rdy)
	);

endmodule

//--- verif/tb_vec_unit.sv
// Fixed-seed random command stream through the four-phase port; one command on the port at a time
`include "vpu_params.svh"

module tb_vec_unit import vpu_pkg::*; ();

	localparam int NTH = `VPU_THREADS;		// Thread count
	localparam int CLK_PERIOD = 100;
	localparam int DRV_DLY = 10;			// Drive offset after rising edge
	localparam int RST_CYCLES = 10;
	localparam int SEED = 36965;
	localparam int N_RAND = 300;			// Random commands
	localparam int N_CMD = N_RAND + NTH + 2;	// Empty STORE, mix, SETENs, final STORE
	localparam int CYC_PER_CMD = 60;		// Handshake plus a fully stalled store walk
	localparam int TIMEOUT_CYC = RST_CYCLES + N_CMD * CYC_PER_CMD;

	logic	clk = 1'b0;
	logic	rst_n;
	logic	cmd_sel;
	cmd_t	cmd;
	logic	cmd_ack;
	logic	wrq_vld;
	wrq_t	wrq;
	logic	wrq_rdy;
	logic	busy;
	logic	end_flag;
	int	val_errs;
	int	proto_errs;
	int	cnt_errs;
	int	pending;			// Results still expected

	always #(CLK_PERIOD / 2) clk = ~clk;

	vpu_vec_unit UUT (
		.clk(clk), .i_rst_n(rst_n),
		.i_cmd_sel(cmd_sel), .i_cmd(cmd), .o_cmd_ack(cmd_ack),
		.o_wrq_vld(wrq_vld), .o_wrq(wrq), .i_wrq_rdy(wrq_rdy),
		.o_busy(busy)
	);

	vpu_checker #(.N_CMD(N_CMD)) chk (
		.clk(clk), .i_rst_n(rst_n),
		.i_cmd_sel(cmd_sel), .i_cmd(cmd), .i_cmd_ack(cmd_ack),
		.i_wrq_vld(wrq_vld), .i_wrq(wrq), .i_wrq_rdy(wrq_rdy),
		.i_busy(busy), .i_end(end_flag),
		.o_val_errs(val_errs), .o_proto_errs(proto_errs),
		.o_cnt_errs(cnt_errs), .o_pending(pending)
	);

	// ======================================================================
	// Command driver
	// ======================================================================

	// Called just after an edge with ack low
	task automatic send_cmd(input cmd_t c);
		cmd = c;
		cmd_sel = 1'b1;
		do begin
			@(posedge clk);
			#DRV_DLY;
		end while (!cmd_ack);		// Stalls here while the queue is full
		cmd_sel = 1'b0;			// Payload held until next command
		do begin
			@(posedge clk);
			#DRV_DLY;
		end while (cmd_ack);
	endtask

	function automatic cmd_t rand_cmd();
		cmd_t		c;
		int unsigned	pick;
		pick = $urandom_range(99, 0);
		c.th = th_t'($urandom_range(NTH - 1, 0));
		c.pl = $urandom();			// Half the SETACC values negative
		c.op = (pick < 25) ? OP_SETACC :
			(pick < 45) ? OP_SETEN :
			(pick < 60) ? OP_ACTF :
			(pick < 80) ? OP_STORE :
			(pick < 88) ? OP_NOP :
			op_t'(5'($urandom_range(31, 5)));	// Undefined opcode
		return c;
	endfunction

	initial begin : stimulus
		cmd_t	c;
		int	total;
		void'($urandom(SEED));
		rst_n = 1'b0;
		cmd_sel = 1'b0;
		cmd = '0;
		end_flag = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#DRV_DLY;
		rst_n = 1'b1;
		@(posedge clk);
		#DRV_DLY;
		c = '0;
		c.op = OP_STORE;
		send_cmd(c);				// No thread enabled yet
		repeat (N_RAND) begin
			send_cmd(rand_cmd());
		end
		for (int t = 0; t < NTH; t++) begin
			c = '0;
			c.op = OP_SETEN;
			c.th = th_t'(t);
			c.pl = pl_t'(1);
			send_cmd(c);
		end
		c = '0;
		c.op = OP_STORE;
		send_cmd(c);				// Emits every accumulator
		// Ends once all expected results arrived or the DUT went idle
		while (pending != 0 && busy) begin
			@(posedge clk);
			#DRV_DLY;
		end
		end_flag = 1'b1;
		@(posedge clk);
		#DRV_DLY;
		total = val_errs + proto_errs + cnt_errs;
		$display("Error counts: value %0d, protocol %0d, transfer %0d",
			val_errs, proto_errs, cnt_errs);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Result sink drives ready high three cycles in four on average
	initial begin : sink
		wrq_rdy = 1'b0;
		forever begin
			@(posedge clk);
			#DRV_DLY;
			wrq_rdy = ($urandom_range(3, 0) != 0);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the command stream never drained", cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- verif/vpu_checker.sv
// Model assumes commands execute in acceptance order; each STORE queues its results on acceptance
`include "vpu_params.svh"

module vpu_checker import vpu_pkg::*; #(
	parameter int N_CMD = 0			// Commands the driver sends
) (
	input  logic	clk,
	input  logic	i_rst_n,
	input  logic	i_cmd_sel,
	input  cmd_t	i_cmd,
	input  logic	i_cmd_ack,
	input  logic	i_wrq_vld,
	input  wrq_t	i_wrq,
	input  logic	i_wrq_rdy,
	input  logic	i_busy,
	input  logic	i_end,			// Stream drained, run end checks
	output int	o_val_errs,
	output int	o_proto_errs,
	output int	o_cnt_errs,
	output int	o_pending
);

	localparam int NTH = `VPU_THREADS;	// Thread count

	acc_t		m_acc [0:NTH-1];	// Model accumulators
	logic [NTH-1:0]	m_en;			// Model enable bits
	wrq_t		exp_q [$];		// Expected results in order
	wrq_t		exp_w;
	wrq_t		wrq_prev;		// Result seen at last edge
	logic		ack_prev = 1'b0;
	logic		sel_prev = 1'b0;
	logic		vld_prev = 1'b0;
	logic		rdy_prev = 1'b0;
	logic		end_done = 1'b0;
	int		rst_cycles = 0;
	int		n_acc = 0;		// Accepted commands
	int		n_pend = 0;		// Expected results not yet seen
	int		val_errs = 0;
	int		proto_errs = 0;
	int		cnt_errs = 0;

	// ======================================================================
	// Reference model
	// ======================================================================

	task automatic apply_cmd(input cmd_t c);
		wrq_t w;
		case (c.op)
		OP_SETACC: m_acc[c.th] = acc_t'(c.pl);
		OP_SETEN: m_en[c.th] = c.pl[0];
		OP_ACTF: begin
			for (int t = 0; t < NTH; t++) begin
				if (m_en[t] && (m_acc[t] < 0)) begin
					if (c.pl[0]) begin
						m_acc[t] = m_acc[t] >>> c.pl[5:1];	// Leaky keeps sign
					end else begin
						m_acc[t] = '0;				// Plain ReLU
					end
				end
			end
		end
		OP_STORE: begin
			for (int t = 0; t < NTH; t++) begin
				if (m_en[t]) begin
					w.th = th_t'(t);
					w.data = m_acc[t];
					exp_q.push_back(w);			// Ascending thread order
				end
			end
		end
		default: ;		// NOP and unknown opcodes leave state alone
		endcase
	endtask

	// ======================================================================
	// Port monitor sampling pre-edge values
	// ======================================================================

	always @(posedge clk) begin
		if (!i_rst_n) begin
			if (rst_cycles > 0 && (i_cmd_ack || i_wrq_vld || i_busy)) begin
				$display("Outputs not low during reset at time %0t", $time);
				proto_errs++;
			end
			rst_cycles++;
			for (int t = 0; t < NTH; t++) begin
				m_acc[t] = '0;
			end
			m_en = '0;
			exp_q.delete();
		end else begin
			if (i_cmd_ack && !ack_prev) begin
				if (!sel_prev) begin
					$display("Ack rose without sel at time %0t", $time);
					proto_errs++;
				end
				n_acc++;
				apply_cmd(i_cmd);			// Command still held by driver
			end
			if (!i_cmd_ack && ack_prev && sel_prev) begin
				$display("Ack dropped while sel high at time %0t", $time);
				proto_errs++;
			end
			if (vld_prev && !rdy_prev) begin		// Stalled result must hold
				if (!i_wrq_vld) begin
					$display("Result valid dropped before transfer at time %0t", $time);
					proto_errs++;
				end else if (i_wrq !== wrq_prev) begin
					$display("** Error at %0t: stalled result changed", $time);
					val_errs++;
				end
			end
			if (i_wrq_vld && i_wrq_rdy) begin
				if (exp_q.size() == 0) begin
					$display("Extra result transfer at time %0t", $time);
					cnt_errs++;
				end else begin
					exp_w = exp_q.pop_front();
					if (i_wrq !== exp_w) begin
						$display("** Error at %0t: got th %0d data %0d, expected th %0d data %0d",
							$time, i_wrq.th, i_wrq.data, exp_w.th, exp_w.data);
						val_errs++;
					end
				end
			end
			if (i_end && !end_done) begin
				end_done = 1'b1;
				if (exp_q.size() != 0) begin
					$display("Missing result transfers: %0d never arrived", exp_q.size());
					cnt_errs += exp_q.size();
				end
				if (n_acc != N_CMD) begin
					$display("Accepted %0d commands but %0d were sent", n_acc, N_CMD);
					proto_errs++;
				end
				if (i_busy) begin
					$display("DUT still busy after the final store");
					proto_errs++;
				end
			end
		end
		ack_prev = i_cmd_ack;
		sel_prev = i_cmd_sel;
		vld_prev = i_wrq_vld;
		rdy_prev = i_wrq_rdy;
		wrq_prev = i_wrq;
		n_pend = exp_q.size();
	end

	assign o_val_errs = val_errs;
	assign o_proto_errs = proto_errs;
	assign o_cnt_errs = cnt_errs;
	assign o_pending = n_pend;

endmodule

//--- vlog.f
+incdir+common
common/vpu_pkg.sv
logic/vpu_cmd_queue.sv
logic/vpu_cmd_dispatch.sv
logic/vpu_rf.sv
actf/vpu_actf_unit.sv
logic/vpu_stor_unit.sv
logic/vpu_vec_unit.sv
verif/vpu_checker.sv
verif/tb_vec_unit.sv
